// ==== common/overlay_pkg.sv ====
`default_nettype none

package overlay_pkg;

    localparam int COORD_W = 11;
    localparam int PIXEL_W = 16;
    localparam int ALPHA_W = 3;

    // Upload raster size
    localparam int RES_X = 800;
    localparam int RES_Y = 600;

    typedef logic [COORD_W-1:0] coord_t;
    typedef logic signed [COORD_W:0] offset_t;
    typedef logic [PIXEL_W-1:0] pixel_t;
    typedef logic [ALPHA_W-1:0] alpha_t;
    typedef logic [7:0] spi_byte_t;
    typedef logic [15:0] cmd_arg_t;

    typedef enum logic [7:0] {
        CMD_RESET            = 8'h00,
        CMD_SET_MODE         = 8'h01,
        CMD_SET_FLAGS        = 8'h02,
        CMD_SET_SCALE        = 8'h03,
        CMD_SET_OFFSET_X     = 8'h04,
        CMD_SET_OFFSET_Y     = 8'h05,
        CMD_SET_TRANSPARENCY = 8'h06,
        CMD_SET_CLIP_LEFT    = 8'h07,
        CMD_SET_CLIP_RIGHT   = 8'h08,
        CMD_SET_CLIP_TOP     = 8'h09,
        CMD_SET_CLIP_BOTTOM  = 8'h0A,
        CMD_SET_FREEZE       = 8'h0B,
        CMD_START_UPLOAD     = 8'h0C,
        CMD_NO_OP            = 8'hFF
    } spi_cmd_e;

    typedef enum logic [2:0] {
        AWAIT_CMD,
        AWAIT_ARG_HI,
        AWAIT_ARG_LO,
        APPLY,
        UPLOAD
    } cmd_state_e;

    // Foreground layer register set
    typedef struct packed {
        logic    freeze;
        logic [1:0] overlay_mode;
        logic [1:0] fg_scale;
        offset_t offset_x;
        offset_t offset_y;
        coord_t  clip_left;
        coord_t  clip_right;
        coord_t  clip_top;
        coord_t  clip_bottom;
        alpha_t  transparency;
    } overlay_ctrl_t;

    typedef struct packed {
        coord_t x;
        coord_t y;
        pixel_t pixel;
    } pixel_write_t;

endpackage

`default_nettype wire

// ==== spi/spi_slave.sv ====
`default_nettype none
`timescale 1ns/1ps

module spi_slave import overlay_pkg::*; (
    input  wire logic clk,
    input  wire logic reset,
    input  wire logic spi_sck,
    input  wire logic spi_ss,
    input  wire logic spi_mosi,
    output logic      spi_miso,
    output spi_byte_t rx_byte,
    output logic      byte_ready,
    output logic      spi_active
);

    // Two sync stages plus one for edge detection on SCK
    logic [2:0] sck_q;
    logic [1:0] ss_q;
    logic [1:0] mosi_q;

    logic       sck_rise;
    logic       sck_fall;
    logic       ss_n;
    logic       mosi_s;

    logic [2:0] bit_cnt;
    logic [6:0] rx_shift;
    spi_byte_t  tx_shift;

    always_ff @(posedge clk) begin
        if (reset) begin
            sck_q <= '0;
            ss_q  <= '1;
        end else begin
            sck_q <= {sck_q[1:0], spi_sck};
            ss_q  <= {ss_q[0], spi_ss};
        end
        mosi_q <= {mosi_q[0], spi_mosi};
    end

    assign ss_n     = ss_q[1];
    assign mosi_s   = mosi_q[1];
    assign sck_rise = !ss_n && sck_q[1] && !sck_q[2];
    assign sck_fall = !ss_n && !sck_q[1] && sck_q[2];

    always_ff @(posedge clk) begin
        if (reset) begin
            bit_cnt    <= '0;
            byte_ready <= 1'b0;
            spi_active <= 1'b0;
            tx_shift   <= '0;
        end else begin
            spi_active <= !ss_n;
            byte_ready <= sck_rise && (bit_cnt == 3'd7);
            if (ss_n) begin
                // Idle between frames, next frame echoes 00 first
                bit_cnt  <= '0;
                tx_shift <= '0;
            end else if (sck_rise) begin
                bit_cnt <= bit_cnt + 3'd1;
                if (bit_cnt == 3'd7) begin
                    tx_shift <= {rx_shift, mosi_s};
                end
            end else if (sck_fall && bit_cnt != 3'd0) begin
                // No shift on the fall that closes a byte
                tx_shift <= {tx_shift[6:0], 1'b0};
            end
        end
    end

    always_ff @(posedge clk) begin
        if (sck_rise) begin
            rx_shift <= {rx_shift[5:0], mosi_s};
            if (bit_cnt == 3'd7) begin
                rx_byte <= {rx_shift, mosi_s};
            end
        end
    end

    assign spi_miso = tx_shift[7];

endmodule

`default_nettype wire

// ==== control/image_upload_receiver.sv ====
`default_nettype none
`timescale 1ns/1ps

module image_upload_receiver import overlay_pkg::*; (
    input  wire logic      clk,
    input  wire logic      reset,
    input  wire logic      upload_enable,
    input  wire spi_byte_t rx_byte,
    input  wire logic      byte_ready,
    output pixel_write_t   pixel_write,
    output logic           pixel_valid
);

    localparam coord_t LAST_X = coord_t'(RES_X - 1);
    localparam coord_t LAST_Y = coord_t'(RES_Y - 1);

    logic      phase;
    spi_byte_t hi_byte;
    coord_t    x;
    coord_t    y;
    logic      pixel_done;

    // Second byte of a pixel
    assign pixel_done = upload_enable && byte_ready && phase;

    always_ff @(posedge clk) begin
        if (reset) begin
            phase       <= 1'b0;
            x           <= '0;
            y           <= '0;
            pixel_valid <= 1'b0;
        end else begin
            pixel_valid <= pixel_done;
            if (!upload_enable) begin
                phase <= 1'b0;
                x     <= '0;
                y     <= '0;
            end else if (byte_ready) begin
                phase <= !phase;
                if (phase) begin
                    // Raster step with wrap at line and frame end
                    if (x == LAST_X) begin
                        x <= '0;
                        if (y == LAST_Y) begin
                            y <= '0;
                        end else begin
                            y <= y + coord_t'(1);
                        end
                    end else begin
                        x <= x + coord_t'(1);
                    end
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (upload_enable && byte_ready && !phase) begin
            hi_byte <= rx_byte;
        end
        if (pixel_done) begin
            pixel_write.x     <= x;
            pixel_write.y     <= y;
            pixel_write.pixel <= {hi_byte, rx_byte};
        end
    end

endmodule

`default_nettype wire

// ==== control/overlay_spi_control.sv ====
`default_nettype none
`timescale 1ns/1ps

module overlay_spi_control import overlay_pkg::*; (
    input  wire logic     clk,
    input  wire logic     reset,
    input  wire logic     spi_sck,
    input  wire logic     spi_ss,
    input  wire logic     spi_mosi,
    output logic          spi_miso,
    output overlay_ctrl_t overlay_ctrl,
    output pixel_write_t  pixel_write,
    output logic          pixel_valid
);

    spi_byte_t  rx_byte;
    logic       byte_ready;
    logic       spi_active;

    cmd_state_e state;
    spi_byte_t  cmd;
    cmd_arg_t   arg;
    logic       upload_enable;

    function automatic logic takes_no_arg(input spi_byte_t code);
        case (code)
            CMD_RESET,
            CMD_NO_OP: return 1'b1;
            default:   return 1'b0;
        endcase
    endfunction

    function automatic logic takes_one_arg(input spi_byte_t code);
        case (code)
            CMD_SET_MODE,
            CMD_SET_FLAGS,
            CMD_SET_SCALE,
            CMD_SET_TRANSPARENCY,
            CMD_SET_FREEZE: return 1'b1;
            default:        return 1'b0;
        endcase
    endfunction

    spi_slave u_spi_slave (
        .clk        (clk),
        .reset      (reset),
        .spi_sck    (spi_sck),
        .spi_ss     (spi_ss),
        .spi_mosi   (spi_mosi),
        .spi_miso   (spi_miso),
        .rx_byte    (rx_byte),
        .byte_ready (byte_ready),
        .spi_active (spi_active)
    );

    // Command FSM
    always_ff @(posedge clk) begin
        if (reset) begin
            state <= AWAIT_CMD;
        end else if (!spi_active && state != APPLY) begin
            // SS went high, drop any partial command or upload
            state <= AWAIT_CMD;
        end else begin
            case (state)
                AWAIT_CMD: begin
                    if (byte_ready) begin
                        if (rx_byte == CMD_START_UPLOAD) begin
                            state <= UPLOAD;
                        end else if (takes_no_arg(rx_byte)) begin
                            state <= APPLY;
                        end else if (takes_one_arg(rx_byte)) begin
                            state <= AWAIT_ARG_LO;
                        end else begin
                            state <= AWAIT_ARG_HI;
                        end
                    end
                end
                AWAIT_ARG_HI: begin
                    if (byte_ready) begin
                        state <= AWAIT_ARG_LO;
                    end
                end
                AWAIT_ARG_LO: begin
                    if (byte_ready) begin
                        state <= APPLY;
                    end
                end
                APPLY: begin
                    state <= AWAIT_CMD;
                end
                UPLOAD: begin
                    // Held until SS deasserts
                    state <= UPLOAD;
                end
                default: begin
                    state <= AWAIT_CMD;
                end
            endcase
        end
    end

    // Command byte and argument capture
    always_ff @(posedge clk) begin
        if (byte_ready) begin
            case (state)
                AWAIT_CMD: begin
                    cmd <= rx_byte;
                    arg <= '0;
                end
                AWAIT_ARG_HI: arg[15:8] <= rx_byte;
                AWAIT_ARG_LO: arg[7:0]  <= rx_byte;
                default: ;
            endcase
        end
    end

    // Foreground register set
    always_ff @(posedge clk) begin
        if (reset) begin
            overlay_ctrl <= '0;
        end else if (state == APPLY) begin
            case (cmd)
                CMD_RESET: begin
                    overlay_ctrl.freeze       <= 1'b0;
                    overlay_ctrl.overlay_mode <= '0;
                    overlay_ctrl.fg_scale     <= '0;
                    overlay_ctrl.offset_x     <= '0;
                    overlay_ctrl.offset_y     <= '0;
                    overlay_ctrl.clip_left    <= '0;
                    overlay_ctrl.clip_right   <= '0;
                    overlay_ctrl.clip_top     <= '0;
                    overlay_ctrl.clip_bottom  <= '0;
                end
                CMD_SET_MODE:         overlay_ctrl.overlay_mode <= arg[1:0];
                CMD_SET_SCALE:        overlay_ctrl.fg_scale     <= arg[1:0];
                CMD_SET_OFFSET_X:     overlay_ctrl.offset_x     <= arg[COORD_W:0];
                CMD_SET_OFFSET_Y:     overlay_ctrl.offset_y     <= arg[COORD_W:0];
                CMD_SET_TRANSPARENCY: overlay_ctrl.transparency <= arg[ALPHA_W-1:0];
                CMD_SET_CLIP_LEFT:    overlay_ctrl.clip_left    <= arg[COORD_W-1:0];
                CMD_SET_CLIP_RIGHT:   overlay_ctrl.clip_right   <= arg[COORD_W-1:0];
                CMD_SET_CLIP_TOP:     overlay_ctrl.clip_top     <= arg[COORD_W-1:0];
                CMD_SET_CLIP_BOTTOM:  overlay_ctrl.clip_bottom  <= arg[COORD_W-1:0];
                CMD_SET_FREEZE:       overlay_ctrl.freeze       <= arg[0];
                // Flags, no-op and unknown codes leave the set alone
                default: ;
            endcase
        end
    end

    assign upload_enable = (state == UPLOAD);

    image_upload_receiver u_image_upload_receiver (
        .clk           (clk),
        .reset         (reset),
        .upload_enable (upload_enable),
        .rx_byte       (rx_byte),
        .byte_ready    (byte_ready),
        .pixel_write   (pixel_write),
        .pixel_valid   (pixel_valid)
    );

endmodule

`default_nettype wire

// ==== logic/overlay_control_top.sv ====
`default_nettype none
`timescale 1ns/1ps

module overlay_control_top import overlay_pkg::*; (
    input  wire logic     clk,
    input  wire logic     reset,
    input  wire logic     spi_sck,
    input  wire logic     spi_ss,
    input  wire logic     spi_mosi,
    output logic          spi_miso,
    output overlay_ctrl_t overlay_ctrl,
    output pixel_write_t  pixel_write,
    output logic          pixel_valid
);

    // Host control port, feeds the overlay pipeline
    overlay_spi_control u_overlay_spi_control (
        .clk          (clk),
        .reset        (reset),
        .spi_sck      (spi_sck),
        .spi_ss       (spi_ss),
        .spi_mosi     (spi_mosi),
        .spi_miso     (spi_miso),
        .overlay_ctrl (overlay_ctrl),
        .pixel_write  (pixel_write),
        .pixel_valid  (pixel_valid)
    );

endmodule

`default_nettype wire

// ==== dv/tb_overlay_control.sv ====
`default_nettype none
`timescale 1ns/1ps

module tb_overlay_control import overlay_pkg::*; ();

    localparam int CLK_PERIOD = 20;
    localparam int HALF_SCK   = 4;
    localparam int BYTE_CLKS  = 16 * HALF_SCK;
    localparam int FRAME_CLKS = 2 * HALF_SCK + 10;
    // Run length estimate with a factor of two margin
    localparam int EST_BYTES   = 2000;
    localparam int EST_FRAMES  = 60;
    localparam int WATCHDOG_NS =
        2 * (EST_BYTES * BYTE_CLKS + EST_FRAMES * FRAME_CLKS) * CLK_PERIOD;

    logic          clk = 1'b0;
    logic          reset;
    logic          spi_sck;
    logic          spi_ss;
    logic          spi_mosi;
    logic          spi_miso;
    overlay_ctrl_t overlay_ctrl;
    pixel_write_t  pixel_write;
    logic          pixel_valid;

    overlay_ctrl_t exp_ctrl;
    spi_byte_t     tx_q[$];
    pixel_write_t  seen_q[$];

    always #(CLK_PERIOD / 2) clk = ~clk;

    overlay_control_top dut (
        .clk          (clk),
        .reset        (reset),
        .spi_sck      (spi_sck),
        .spi_ss       (spi_ss),
        .spi_mosi     (spi_mosi),
        .spi_miso     (spi_miso),
        .overlay_ctrl (overlay_ctrl),
        .pixel_write  (pixel_write),
        .pixel_valid  (pixel_valid)
    );

    // Pixel monitor on the falling clock edge
    always @(negedge clk) begin
        if (pixel_valid) begin
            seen_q.push_back(pixel_write);
        end
    end

    initial begin
        #(WATCHDOG_NS);
        $display("timeout: tests still running after %0d ns", WATCHDOG_NS);
        $display("Verification failed");
        $fatal(1, "watchdog expired");
    end

    task automatic wait_cycles(input int n);
        repeat (n) @(posedge clk);
        #2;
    endtask

    task automatic mismatch_abort(input string name, input logic [31:0] expected,
                                  input logic [31:0] actual);
        $display("mismatch at %0t ns: %s expected %h got %h", $time, name, expected, actual);
        $display("Verification failed");
        $fatal(1, "stopping at first error");
    endtask

    task automatic check_field(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (actual === expected) else mismatch_abort(name, expected, actual);
    endtask

    function automatic int arg_bytes(input spi_byte_t code);
        case (code)
            CMD_RESET, CMD_NO_OP: return 0;
            CMD_SET_MODE, CMD_SET_FLAGS, CMD_SET_SCALE,
            CMD_SET_TRANSPARENCY, CMD_SET_FREEZE: return 1;
            default: return 2;
        endcase
    endfunction

    // Reference register set
    task automatic update_model(input spi_byte_t code, input cmd_arg_t a);
        case (code)
            CMD_RESET: begin
                exp_ctrl.freeze       = 1'b0;
                exp_ctrl.overlay_mode = 2'd0;
                exp_ctrl.fg_scale     = 2'd0;
                exp_ctrl.offset_x     = '0;
                exp_ctrl.offset_y     = '0;
                exp_ctrl.clip_left    = '0;
                exp_ctrl.clip_right   = '0;
                exp_ctrl.clip_top     = '0;
                exp_ctrl.clip_bottom  = '0;
            end
            CMD_SET_MODE:         exp_ctrl.overlay_mode = a[1:0];
            CMD_SET_SCALE:        exp_ctrl.fg_scale     = a[1:0];
            CMD_SET_OFFSET_X:     exp_ctrl.offset_x     = $signed(a[11:0]);
            CMD_SET_OFFSET_Y:     exp_ctrl.offset_y     = $signed(a[11:0]);
            CMD_SET_TRANSPARENCY: exp_ctrl.transparency = a[2:0];
            CMD_SET_CLIP_LEFT:    exp_ctrl.clip_left    = a[10:0];
            CMD_SET_CLIP_RIGHT:   exp_ctrl.clip_right   = a[10:0];
            CMD_SET_CLIP_TOP:     exp_ctrl.clip_top     = a[10:0];
            CMD_SET_CLIP_BOTTOM:  exp_ctrl.clip_bottom  = a[10:0];
            CMD_SET_FREEZE:       exp_ctrl.freeze       = a[0];
            default: ;
        endcase
    endtask

    task automatic queue_command(input spi_byte_t code, input cmd_arg_t arg);
        int n;
        n = arg_bytes(code);
        tx_q.push_back(code);
        if (n == 2) begin
            tx_q.push_back(arg[15:8]);
        end
        if (n >= 1) begin
            tx_q.push_back(arg[7:0]);
        end
        update_model(code, (n == 1) ? {8'h00, arg[7:0]} : arg);
    endtask

    // Mode 0 byte with MISO captured on the rising SCK edge
    task automatic spi_transfer(input spi_byte_t tx, output spi_byte_t rx);
        int i;
        for (i = 7; i >= 0; i--) begin
            spi_mosi = tx[i];
            wait_cycles(HALF_SCK);
            spi_sck = 1'b1;
            rx[i] = spi_miso;
            wait_cycles(HALF_SCK);
            spi_sck = 1'b0;
        end
    endtask

    // Sends tx_q in one SS frame and checks the MISO loopback
    task automatic send_frame();
        spi_byte_t echo;
        spi_byte_t prev;
        prev = 8'h00;
        spi_ss = 1'b0;
        wait_cycles(HALF_SCK);
        foreach (tx_q[k]) begin
            spi_transfer(tx_q[k], echo);
            check_field("spi_miso byte", 32'(prev), 32'(echo));
            prev = tx_q[k];
        end
        wait_cycles(HALF_SCK);
        spi_ss = 1'b1;
        tx_q.delete();
        wait_cycles(10);
    endtask

    task automatic check_ctrl();
        check_field("overlay_ctrl.freeze", 32'(exp_ctrl.freeze), 32'(overlay_ctrl.freeze));
        check_field("overlay_ctrl.overlay_mode", 32'(exp_ctrl.overlay_mode),
                    32'(overlay_ctrl.overlay_mode));
        check_field("overlay_ctrl.fg_scale", 32'(exp_ctrl.fg_scale), 32'(overlay_ctrl.fg_scale));
        check_field("overlay_ctrl.offset_x", 32'(exp_ctrl.offset_x), 32'(overlay_ctrl.offset_x));
        check_field("overlay_ctrl.offset_y", 32'(exp_ctrl.offset_y), 32'(overlay_ctrl.offset_y));
        check_field("overlay_ctrl.clip_left", 32'(exp_ctrl.clip_left),
                    32'(overlay_ctrl.clip_left));
        check_field("overlay_ctrl.clip_right", 32'(exp_ctrl.clip_right),
                    32'(overlay_ctrl.clip_right));
        check_field("overlay_ctrl.clip_top", 32'(exp_ctrl.clip_top), 32'(overlay_ctrl.clip_top));
        check_field("overlay_ctrl.clip_bottom", 32'(exp_ctrl.clip_bottom),
                    32'(overlay_ctrl.clip_bottom));
        check_field("overlay_ctrl.transparency", 32'(exp_ctrl.transparency),
                    32'(overlay_ctrl.transparency));
    endtask

    task automatic test_reset_values();
        wait_cycles(20);
        check_ctrl();
        check_field("pixel_valid count", 32'd0, 32'(seen_q.size()));
    endtask

    task automatic test_set_commands();
        spi_byte_t set_cmds [10];
        cmd_arg_t  arg;
        int        round;
        set_cmds = '{CMD_SET_MODE, CMD_SET_SCALE, CMD_SET_TRANSPARENCY, CMD_SET_FREEZE,
                     CMD_SET_OFFSET_X, CMD_SET_OFFSET_Y, CMD_SET_CLIP_LEFT,
                     CMD_SET_CLIP_RIGHT, CMD_SET_CLIP_TOP, CMD_SET_CLIP_BOTTOM};
        for (round = 0; round < 2; round++) begin
            foreach (set_cmds[k]) begin
                arg = 16'($urandom);
                // Negative offsets in the first round
                if (set_cmds[k] == CMD_SET_OFFSET_X || set_cmds[k] == CMD_SET_OFFSET_Y) begin
                    arg[11] = (round == 0);
                end
                queue_command(set_cmds[k], arg);
                send_frame();
                check_ctrl();
            end
        end
        queue_command(CMD_SET_FLAGS, 16'($urandom));
        send_frame();
        check_ctrl();
        queue_command(8'(8'h0D + $urandom % 242), 16'($urandom));
        queue_command(CMD_SET_SCALE, 16'($urandom));
        queue_command(CMD_SET_FLAGS, 16'($urandom));
        queue_command(CMD_SET_CLIP_TOP, 16'($urandom));
        send_frame();
        check_ctrl();
        check_field("pixel_valid count", 32'd0, 32'(seen_q.size()));
    endtask

    task automatic test_reset_and_noop();
        queue_command(CMD_SET_TRANSPARENCY, 16'h0005);
        queue_command(CMD_SET_MODE, 16'h0002);
        send_frame();
        check_ctrl();
        queue_command(CMD_NO_OP, 16'h0000);
        send_frame();
        check_ctrl();
        queue_command(CMD_RESET, 16'h0000);
        send_frame();
        check_ctrl();
    endtask

    task automatic test_aborted_command();
        // Frame ends after the high argument byte
        tx_q.push_back(CMD_SET_OFFSET_X);
        tx_q.push_back(8'h0A);
        send_frame();
        check_ctrl();
        queue_command(CMD_SET_OFFSET_X, 16'($urandom));
        send_frame();
        check_ctrl();
    endtask

    task automatic test_upload(input int n_pix);
        pixel_t       pix[$];
        pixel_t       p;
        pixel_write_t got;
        int           k;
        seen_q.delete();
        tx_q.push_back(CMD_START_UPLOAD);
        for (k = 0; k < n_pix; k++) begin
            p = 16'($urandom);
            pix.push_back(p);
            tx_q.push_back(p[15:8]);
            tx_q.push_back(p[7:0]);
        end
        send_frame();
        check_field("pixel_valid count", 32'(n_pix), 32'(seen_q.size()));
        for (k = 0; k < n_pix; k++) begin
            got = seen_q[k];
            check_field("pixel_write.x", 32'(k % RES_X), 32'(got.x));
            check_field("pixel_write.y", 32'((k / RES_X) % RES_Y), 32'(got.y));
            check_field("pixel_write.pixel", 32'(pix[k]), 32'(got.pixel));
        end
        check_ctrl();
    endtask

    task automatic test_miso_echo();
        int k;
        for (k = 0; k < 16; k++) begin
            queue_command(CMD_SET_FLAGS, 16'($urandom));
        end
        send_frame();
        check_ctrl();
    endtask

    initial begin
        void'($urandom(32'h65c0));
        reset    = 1'b1;
        spi_sck  = 1'b0;
        spi_ss   = 1'b1;
        spi_mosi = 1'b0;
        exp_ctrl = '0;
        wait_cycles(4);
        reset = 1'b0;

        test_reset_values();
        test_set_commands();
        test_reset_and_noop();
        test_aborted_command();
        test_upload(803);
        test_upload(3);
        test_miso_echo();

        $display("Verification passed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== tb.f ====
common/overlay_pkg.sv
spi/spi_slave.sv
control/image_upload_receiver.sv
control/overlay_spi_control.sv
logic/overlay_control_top.sv
dv/tb_overlay_control.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build with Verilator, run, and decide the result from the log
rm -f sim.log
verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tb_overlay_control -f tb.f -o sim_overlay || exit 1
./obj_dir/sim_overlay > sim.log 2>&1
cat sim.log
grep -q "Verification failed" sim.log && exit 1
grep -q "Verification passed" sim.log || exit 1
exit 0
